// File: src/rename_pkg.sv
/*
 * Shared sizes for the register-rename block: register files, rename
 * width, free-list pointers and checkpoint slots
 */

package rename_pkg;

  //////////////////////////////////////////////////
  // Rename group
  //////////////////////////////////////////////////

  // Instructions renamed per cycle
  localparam int RENAME_WIDTH = 2;

  //////////////////////////////////////////////////
  // Register files
  //////////////////////////////////////////////////

  localparam int ARF_SIZE       = 32;
  localparam int ARF_INDEX_SIZE = 5;

  localparam int PRF_SIZE       = 64;
  localparam int PRF_INDEX_SIZE = 6;

  // One extra bit tells a full list from an empty one
  localparam int FL_PTR_SIZE    = PRF_INDEX_SIZE + 1;

  //////////////////////////////////////////////////
  // Checkpoints
  //////////////////////////////////////////////////

  localparam int CP_COUNT       = 4;
  localparam int CP_INDEX_SIZE  = 2;

endpackage

// File: src/rename_map_table.sv
/*
 * Architectural to physical mapping table with mapped bits, in-group
 * RAW/WAW forwarding and single-cycle recovery from a checkpoint copy
 */

module rename_map_table
  import rename_pkg::*;
(
  input  logic                                           clock,
  input  logic                                           reset,
  input  logic                                           recover,

  input  logic [RENAME_WIDTH-1:0]                        rd_valid,
  input  logic [RENAME_WIDTH-1:0][ARF_INDEX_SIZE-1:0]    rs1,
  input  logic [RENAME_WIDTH-1:0][ARF_INDEX_SIZE-1:0]    rs2,
  input  logic [RENAME_WIDTH-1:0][ARF_INDEX_SIZE-1:0]    rd,

  // Next free registers, in lane order
  input  logic [RENAME_WIDTH-1:0][PRF_INDEX_SIZE-1:0]    prf_out,

  // Snapshot selected for recovery
  input  logic [ARF_SIZE-1:0][PRF_INDEX_SIZE-1:0]        table_cp,
  input  logic [ARF_SIZE-1:0]                            mapped_cp,

  output logic [RENAME_WIDTH-1:0][PRF_INDEX_SIZE-1:0]    prs1,
  output logic [RENAME_WIDTH-1:0][PRF_INDEX_SIZE-1:0]    prs2,
  output logic [RENAME_WIDTH-1:0][PRF_INDEX_SIZE-1:0]    prd,
  output logic [RENAME_WIDTH-1:0][PRF_INDEX_SIZE-1:0]    prev_rd,
  output logic [RENAME_WIDTH-1:0]                        prev_rd_valid,

  // Current state, fed to the checkpoint storage
  output logic [ARF_SIZE-1:0][PRF_INDEX_SIZE-1:0]        table_state,
  output logic [ARF_SIZE-1:0]                            mapped_state
);

  logic [ARF_SIZE-1:0][PRF_INDEX_SIZE-1:0] table_q;
  logic [ARF_SIZE-1:0][PRF_INDEX_SIZE-1:0] table_next;
  logic [ARF_SIZE-1:0]                     mapped_q;
  logic [ARF_SIZE-1:0]                     mapped_next;

  //////////////////////////////////////////////////
  // Lane walk
  //////////////////////////////////////////////////

  // Each lane sees the table as left by the lanes before it.
  // Sources are read before the lane's own destination is written.
  always_comb begin
    table_next  = table_q;
    mapped_next = mapped_q;

    for (int i = 0; i < RENAME_WIDTH; i++) begin
      prs1[i]          = table_next[rs1[i]];
      prs2[i]          = table_next[rs2[i]];
      prd[i]           = '0;
      prev_rd[i]       = '0;
      prev_rd_valid[i] = 1'b0;

      if (rd_valid[i]) begin
        // Old mapping, possibly an earlier lane's prd (WAW)
        prev_rd[i]       = table_next[rd[i]];
        prev_rd_valid[i] = mapped_next[rd[i]];
        prd[i]           = prf_out[i];

        table_next[rd[i]]  = prf_out[i];
        mapped_next[rd[i]] = 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // State update
  //////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      table_q  <= '0;
      mapped_q <= '0;
    end else if (recover) begin
      // Renames in this cycle are dropped
      table_q  <= table_cp;
      mapped_q <= mapped_cp;
    end else begin
      table_q  <= table_next;
      mapped_q <= mapped_next;
    end
  end

  assign table_state  = table_q;
  assign mapped_state = mapped_q;

endmodule

// File: src/rename_free_list.sv
/*
 * Circular free list of physical registers with per-checkpoint head copies
 */

module rename_free_list
  import rename_pkg::*;
(
  input  logic                                           clock,
  input  logic                                           reset,

  input  logic                                           check,
  input  logic                                           recover,
  input  logic [CP_INDEX_SIZE-1:0]                       check_idx,
  input  logic [CP_INDEX_SIZE-1:0]                       recover_idx,

  // One pop per requesting lane
  input  logic [RENAME_WIDTH-1:0]                        prf_req,

  // Registers returned by retirement
  input  logic [RENAME_WIDTH-1:0]                        retire_req,
  input  logic [RENAME_WIDTH-1:0][PRF_INDEX_SIZE-1:0]    retire_prf,

  output logic [RENAME_WIDTH-1:0][PRF_INDEX_SIZE-1:0]    prf_out,
  output logic                                           allocatable
);

  logic [PRF_INDEX_SIZE-1:0] fl_mem [PRF_SIZE];

  logic [FL_PTR_SIZE-1:0] head_ptr;
  logic [FL_PTR_SIZE-1:0] tail_ptr;
  logic [FL_PTR_SIZE-1:0] head_cp [CP_COUNT];

  // Slot indices without the wrap bit
  logic [RENAME_WIDTH-1:0][PRF_INDEX_SIZE-1:0] pop_ptr;
  logic [RENAME_WIDTH-1:0][PRF_INDEX_SIZE-1:0] push_ptr;
  logic [FL_PTR_SIZE-1:0]                      pop_count;
  logic [FL_PTR_SIZE-1:0]                      push_count;
  logic [FL_PTR_SIZE-1:0]                      free_count;

  // Lanes without a request take no slot, so later lanes move up
  always_comb begin
    pop_count  = '0;
    push_count = '0;
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      pop_ptr[i]  = PRF_INDEX_SIZE'(head_ptr + pop_count);
      push_ptr[i] = PRF_INDEX_SIZE'(tail_ptr + push_count);
      if (prf_req[i]) begin
        pop_count = pop_count + FL_PTR_SIZE'(1);
      end
      if (retire_req[i]) begin
        push_count = push_count + FL_PTR_SIZE'(1);
      end
    end
  end

  always_comb begin
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      prf_out[i] = fl_mem[pop_ptr[i]];
    end
  end

  assign free_count  = tail_ptr - head_ptr;
  assign allocatable = (free_count >= FL_PTR_SIZE'(RENAME_WIDTH));

  //////////////////////////////////////////////////
  // Storage and pointers
  //////////////////////////////////////////////////

  // Starts full with registers 0 to 63 in order
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < PRF_SIZE; i++) begin
        fl_mem[i] <= PRF_INDEX_SIZE'(i);
      end
    end else begin
      for (int i = 0; i < RENAME_WIDTH; i++) begin
        if (retire_req[i]) begin
          fl_mem[push_ptr[i]] <= retire_prf[i];
        end
      end
    end
  end

  // Tail keeps moving on recover, so retires there are kept
  always_ff @(posedge clock) begin
    if (reset) begin
      head_ptr <= '0;
      tail_ptr <= FL_PTR_SIZE'(PRF_SIZE);
    end else begin
      tail_ptr <= tail_ptr + push_count;
      if (recover) begin
        head_ptr <= head_cp[recover_idx];
      end else begin
        head_ptr <= head_ptr + pop_count;
      end
    end
  end

  // Head as it was before this cycle's pops
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < CP_COUNT; i++) begin
        head_cp[i] <= '0;
      end
    end else if (check) begin
      head_cp[check_idx] <= head_ptr;
    end
  end

endmodule

// File: src/rename_checkpoint.sv
/*
 * Checkpoint slots holding copies of the mapping table and mapped bits
 */

module rename_checkpoint
  import rename_pkg::*;
(
  input  logic                                      clock,
  input  logic                                      reset,

  input  logic                                      check,
  input  logic [CP_INDEX_SIZE-1:0]                  check_idx,
  input  logic [CP_INDEX_SIZE-1:0]                  recover_idx,

  input  logic [ARF_SIZE-1:0][PRF_INDEX_SIZE-1:0]   table_in,
  input  logic [ARF_SIZE-1:0]                       mapped_in,

  output logic [ARF_SIZE-1:0][PRF_INDEX_SIZE-1:0]   table_out,
  output logic [ARF_SIZE-1:0]                       mapped_out
);

  logic [CP_COUNT-1:0][ARF_SIZE-1:0][PRF_INDEX_SIZE-1:0] cp_table;
  logic [CP_COUNT-1:0][ARF_SIZE-1:0]                     cp_mapped;

  // Snapshot of the registered state, taken before the cycle's renames
  always_ff @(posedge clock) begin
    if (reset) begin
      cp_table  <= '0;
      cp_mapped <= '0;
    end else if (check) begin
      cp_table[check_idx]  <= table_in;
      cp_mapped[check_idx] <= mapped_in;
    end
  end

  // Read side is combinational for one-cycle recovery
  assign table_out  = cp_table[recover_idx];
  assign mapped_out = cp_mapped[recover_idx];

endmodule

// File: src/rename_stage.sv
/*
 * Rename stage top level: mapping table, free list and checkpoint storage
 */

module rename_stage
  import rename_pkg::*;
(
  input  logic                                           clock,
  input  logic                                           reset,

  input  logic                                           check,
  input  logic                                           recover,
  input  logic [CP_INDEX_SIZE-1:0]                       check_idx,
  input  logic [CP_INDEX_SIZE-1:0]                       recover_idx,

  input  logic [RENAME_WIDTH-1:0]                        rd_valid,
  input  logic [RENAME_WIDTH-1:0][ARF_INDEX_SIZE-1:0]    rs1,
  input  logic [RENAME_WIDTH-1:0][ARF_INDEX_SIZE-1:0]    rs2,
  input  logic [RENAME_WIDTH-1:0][ARF_INDEX_SIZE-1:0]    rd,

  input  logic [RENAME_WIDTH-1:0]                        retire_req,
  input  logic [RENAME_WIDTH-1:0][PRF_INDEX_SIZE-1:0]    retire_prf,

  output logic [RENAME_WIDTH-1:0][PRF_INDEX_SIZE-1:0]    prs1,
  output logic [RENAME_WIDTH-1:0][PRF_INDEX_SIZE-1:0]    prs2,
  output logic [RENAME_WIDTH-1:0][PRF_INDEX_SIZE-1:0]    prd,
  output logic [RENAME_WIDTH-1:0][PRF_INDEX_SIZE-1:0]    prev_rd,
  output logic [RENAME_WIDTH-1:0]                        prev_rd_valid,
  output logic                                           allocatable
);

  logic [RENAME_WIDTH-1:0][PRF_INDEX_SIZE-1:0] prf_out;
  logic [ARF_SIZE-1:0][PRF_INDEX_SIZE-1:0]     table_state;
  logic [ARF_SIZE-1:0]                         mapped_state;
  logic [ARF_SIZE-1:0][PRF_INDEX_SIZE-1:0]     table_cp;
  logic [ARF_SIZE-1:0]                         mapped_cp;

  rename_map_table rename_map_table_i (
    .clock         (clock),
    .reset         (reset),
    .recover       (recover),
    .rd_valid      (rd_valid),
    .rs1           (rs1),
    .rs2           (rs2),
    .rd            (rd),
    .prf_out       (prf_out),
    .table_cp      (table_cp),
    .mapped_cp     (mapped_cp),
    .prs1          (prs1),
    .prs2          (prs2),
    .prd           (prd),
    .prev_rd       (prev_rd),
    .prev_rd_valid (prev_rd_valid),
    .table_state   (table_state),
    .mapped_state  (mapped_state)
  );

  // Head snapshots live inside the free list
  rename_free_list rename_free_list_i (
    .clock       (clock),
    .reset       (reset),
    .check       (check),
    .recover     (recover),
    .check_idx   (check_idx),
    .recover_idx (recover_idx),
    .prf_req     (rd_valid),
    .retire_req  (retire_req),
    .retire_prf  (retire_prf),
    .prf_out     (prf_out),
    .allocatable (allocatable)
  );

  rename_checkpoint rename_checkpoint_i (
    .clock       (clock),
    .reset       (reset),
    .check       (check),
    .check_idx   (check_idx),
    .recover_idx (recover_idx),
    .table_in    (table_state),
    .mapped_in   (mapped_state),
    .table_out   (table_cp),
    .mapped_out  (mapped_cp)
  );

endmodule

// File: testbench/rename_stage_asserts.sv
/*
 * Bound assertions on the usage rules of the rename stage ports
 */

module rename_stage_asserts
  import rename_pkg::*;
(
  input logic                     clock,
  input logic                     reset,
  input logic                     check,
  input logic                     recover,
  input logic [CP_INDEX_SIZE-1:0] check_idx,
  input logic [CP_INDEX_SIZE-1:0] recover_idx,
  input logic [RENAME_WIDTH-1:0]  rd_valid,
  input logic                     allocatable
);

  // Slots written since the last reset
  logic [CP_COUNT-1:0] checked_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      checked_q <= '0;
    end else if (check) begin
      checked_q[check_idx] <= 1'b1;
    end
  end

  rd_valid_needs_allocatable: assert property (@(posedge clock) disable iff (reset)
    (rd_valid != '0) |-> allocatable) else $error("rename requested while not allocatable");

  check_recover_exclusive: assert property (@(posedge clock) disable iff (reset)
    !(check && recover)) else $error("check and recover in the same cycle");

  recover_checked_slot: assert property (@(posedge clock) disable iff (reset)
    recover |-> checked_q[recover_idx]) else $error("recover from a slot never checked");

  allocatable_after_reset: assert property (@(posedge clock)
    $fell(reset) |-> allocatable) else $error("allocatable low after reset");

endmodule

bind rename_stage rename_stage_asserts rename_stage_asserts_i (.*);

// File: testbench/rename_stage_tb.sv
/*
 * Testbench for the rename stage: clock, reset, reference model,
 * compare tasks and directed tests
 */

module rename_stage_tb
  import rename_pkg::*;
;

  logic clock;
  logic reset;
  logic check;
  logic recover;
  logic [CP_INDEX_SIZE-1:0] check_idx;
  logic [CP_INDEX_SIZE-1:0] recover_idx;
  logic [RENAME_WIDTH-1:0] rd_valid;
  logic [RENAME_WIDTH-1:0][ARF_INDEX_SIZE-1:0] rs1;
  logic [RENAME_WIDTH-1:0][ARF_INDEX_SIZE-1:0] rs2;
  logic [RENAME_WIDTH-1:0][ARF_INDEX_SIZE-1:0] rd;
  logic [RENAME_WIDTH-1:0] retire_req;
  logic [RENAME_WIDTH-1:0][PRF_INDEX_SIZE-1:0] retire_prf;
  logic [RENAME_WIDTH-1:0][PRF_INDEX_SIZE-1:0] prs1;
  logic [RENAME_WIDTH-1:0][PRF_INDEX_SIZE-1:0] prs2;
  logic [RENAME_WIDTH-1:0][PRF_INDEX_SIZE-1:0] prd;
  logic [RENAME_WIDTH-1:0][PRF_INDEX_SIZE-1:0] prev_rd;
  logic [RENAME_WIDTH-1:0] prev_rd_valid;
  logic allocatable;

  // Reference model state
  logic [PRF_INDEX_SIZE-1:0] m_fl [PRF_SIZE];
  logic [FL_PTR_SIZE-1:0] m_head;
  logic [FL_PTR_SIZE-1:0] m_tail;
  logic [PRF_INDEX_SIZE-1:0] m_table [ARF_SIZE];
  logic m_mapped [ARF_SIZE];
  logic [PRF_INDEX_SIZE-1:0] cp_table [CP_COUNT][ARF_SIZE];
  logic cp_mapped [CP_COUNT][ARF_SIZE];
  logic [FL_PTR_SIZE-1:0] cp_head [CP_COUNT];
  logic [CP_COUNT-1:0] cp_used;

  // Expected results of the last step
  logic [RENAME_WIDTH-1:0][PRF_INDEX_SIZE-1:0] last_prev;
  logic [RENAME_WIDTH-1:0] last_prev_valid;

  logic [31:0] lfsr;
  int errors;
  int tests_done;
  int tests_clean;

  rename_stage rename_stage_i (.*);

  always #5 clock = ~clock;

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] take_bits(int n);
    logic [31:0] value;
    logic fb;
    value = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      value = {value[30:0], fb};
    end
    return value;
  endfunction

  task automatic compare_preg(string name, logic [PRF_INDEX_SIZE-1:0] expected,
                              logic [PRF_INDEX_SIZE-1:0] actual);
    if (expected !== actual) begin
      $display("Mismatch %s: expected %h, got %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic compare_bit(string name, logic expected, logic actual);
    if (expected !== actual) begin
      $display("Mismatch %s: expected %h, got %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic idle_inputs();
    check = 1'b0;
    recover = 1'b0;
    check_idx = '0;
    recover_idx = '0;
    rd_valid = '0;
    rs1 = '0;
    rs2 = '0;
    rd = '0;
    retire_req = '0;
    retire_prf = '0;
  endtask

  task automatic apply_reset();
    reset = 1'b1;
    idle_inputs();
    repeat (4) @(posedge clock);
    #1;
    reset = 1'b0;
    for (int i = 0; i < PRF_SIZE; i++) begin
      m_fl[i] = PRF_INDEX_SIZE'(i);
    end
    for (int i = 0; i < ARF_SIZE; i++) begin
      m_table[i] = '0;
      m_mapped[i] = 1'b0;
    end
    for (int c = 0; c < CP_COUNT; c++) begin
      cp_table[c] = m_table;
      cp_mapped[c] = m_mapped;
      cp_head[c] = '0;
    end
    m_head = '0;
    m_tail = FL_PTR_SIZE'(PRF_SIZE);
    cp_used = '0;
  endtask

  // Called 1 unit after a rising edge
  // Compares mid cycle, then updates the model at the next edge
  task automatic step();
    logic [PRF_INDEX_SIZE-1:0] t_table [ARF_SIZE];
    logic t_mapped [ARF_SIZE];
    logic [PRF_INDEX_SIZE-1:0] ptr;
    logic [FL_PTR_SIZE-1:0] pops;
    logic [FL_PTR_SIZE-1:0] pushes;
    logic [PRF_INDEX_SIZE-1:0] e_prd;
    #3;
    t_table = m_table;
    t_mapped = m_mapped;
    pops = '0;
    compare_bit("allocatable", (m_tail - m_head) >= FL_PTR_SIZE'(RENAME_WIDTH), allocatable);
    for (int l = 0; l < RENAME_WIDTH; l++) begin
      compare_preg($sformatf("prs1[%0d]", l), t_table[rs1[l]], prs1[l]);
      compare_preg($sformatf("prs2[%0d]", l), t_table[rs2[l]], prs2[l]);
      last_prev[l] = '0;
      last_prev_valid[l] = 1'b0;
      e_prd = '0;
      if (rd_valid[l]) begin
        ptr = PRF_INDEX_SIZE'(m_head + pops);
        e_prd = m_fl[ptr];
        last_prev[l] = t_table[rd[l]];
        last_prev_valid[l] = t_mapped[rd[l]];
        t_table[rd[l]] = e_prd;
        t_mapped[rd[l]] = 1'b1;
        pops = pops + FL_PTR_SIZE'(1);
      end
      compare_preg($sformatf("prd[%0d]", l), e_prd, prd[l]);
      compare_preg($sformatf("prev_rd[%0d]", l), last_prev[l], prev_rd[l]);
      compare_bit($sformatf("prev_rd_valid[%0d]", l), last_prev_valid[l], prev_rd_valid[l]);
    end
    @(posedge clock);
    pushes = '0;
    for (int l = 0; l < RENAME_WIDTH; l++) begin
      if (retire_req[l]) begin
        ptr = PRF_INDEX_SIZE'(m_tail + pushes);
        m_fl[ptr] = retire_prf[l];
        pushes = pushes + FL_PTR_SIZE'(1);
      end
    end
    m_tail = m_tail + pushes;
    if (check) begin
      cp_table[check_idx] = m_table;
      cp_mapped[check_idx] = m_mapped;
      cp_head[check_idx] = m_head;
      cp_used[check_idx] = 1'b1;
    end
    if (recover) begin
      m_table = cp_table[recover_idx];
      m_mapped = cp_mapped[recover_idx];
      m_head = cp_head[recover_idx];
    end else begin
      m_table = t_table;
      m_mapped = t_mapped;
      m_head = m_head + pops;
    end
    #1;
    idle_inputs();
  endtask

  task automatic wait_allocatable(int limit);
    int cycles;
    cycles = 0;
    while (!allocatable && cycles < limit) begin
      step();
      cycles++;
    end
    if (!allocatable) begin
      $display("Timeout: allocatable stayed low for %0d cycles", limit);
      errors++;
    end
  endtask

  task automatic report(string name, int errors_before);
    tests_done++;
    if (errors == errors_before) begin
      tests_clean++;
    end
    $display("%s finished with %0d errors", name, errors - errors_before);
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic test_basic_rename();
    int e0;
    e0 = errors;
    apply_reset();
    rs1 = {5'd7, 5'd3};
    rs2 = {5'd9, 5'd1};
    step();
    rd_valid = 2'b11;
    rd = {5'd5, 5'd3};
    #3;
    compare_preg("prd[0]", 6'h00, prd[0]);
    compare_preg("prd[1]", 6'h01, prd[1]);
    compare_bit("prev_rd_valid[0]", 1'b0, prev_rd_valid[0]);
    step();
    rd_valid = 2'b01;
    rd[0] = 5'd3;
    #3;
    compare_preg("prd[0]", 6'h02, prd[0]);
    compare_preg("prev_rd[0]", 6'h00, prev_rd[0]);
    compare_bit("prev_rd_valid[0]", 1'b1, prev_rd_valid[0]);
    step();
    report("test_basic_rename", e0);
  endtask

  task automatic test_group_hazards();
    int e0;
    e0 = errors;
    apply_reset();
    // Use up registers 0 and 1 so forwarded values differ from reset mappings
    rd_valid = 2'b11;
    rd = {5'd1, 5'd0};
    step();
    rd_valid = 2'b11;
    rd = {5'd4, 5'd4};
    rs1 = {5'd4, 5'd4};
    rs2[1] = 5'd4;
    #3;
    compare_preg("prs1[0]", 6'h00, prs1[0]);
    compare_preg("prd[0]", 6'h02, prd[0]);
    compare_preg("prs1[1]", 6'h02, prs1[1]);
    compare_preg("prs2[1]", 6'h02, prs2[1]);
    compare_preg("prev_rd[1]", 6'h02, prev_rd[1]);
    compare_bit("prev_rd_valid[1]", 1'b1, prev_rd_valid[1]);
    compare_preg("prd[1]", 6'h03, prd[1]);
    step();
    rd_valid = 2'b10;
    rd = {5'd6, 5'd2};
    #3;
    compare_preg("prd[1]", 6'h04, prd[1]);
    step();
    report("test_group_hazards", e0);
  endtask

  task automatic test_exhaustion();
    int e0;
    e0 = errors;
    apply_reset();
    for (int g = 0; g < PRF_SIZE / 2; g++) begin
      rd_valid = 2'b11;
      rd = {5'(2 * g + 1), 5'(2 * g)};
      step();
    end
    compare_bit("allocatable", 1'b0, allocatable);
    retire_req = 2'b11;
    retire_prf = {6'd7, 6'd10};
    step();
    wait_allocatable(10);
    rd_valid = 2'b11;
    rd = {5'd1, 5'd0};
    #3;
    compare_preg("prd[0]", 6'h0a, prd[0]);
    compare_preg("prd[1]", 6'h07, prd[1]);
    step();
    report("test_exhaustion", e0);
  endtask

  task automatic test_checkpoint();
    int e0;
    e0 = errors;
    apply_reset();
    rd_valid = 2'b11;
    rd = {5'd2, 5'd1};
    step();
    // x1 moves to register 2, leaving register 0 as its old mapping
    rd_valid = 2'b01;
    rd[0] = 5'd1;
    step();
    check = 1'b1;
    check_idx = 2'd1;
    step();
    for (int g = 0; g < 3; g++) begin
      rd_valid = 2'b11;
      rd = {5'd2, 5'd1};
      step();
    end
    recover = 1'b1;
    recover_idx = 2'd1;
    retire_req = 2'b01;
    retire_prf[0] = 6'd0;
    step();
    rs1 = {5'd2, 5'd1};
    rd_valid = 2'b11;
    rd = {5'd4, 5'd3};
    #3;
    compare_preg("prs1[0]", 6'h02, prs1[0]);
    compare_preg("prs1[1]", 6'h01, prs1[1]);
    compare_preg("prd[0]", 6'h03, prd[0]);
    compare_preg("prd[1]", 6'h04, prd[1]);
    step();
    for (int g = 0; g < 29; g++) begin
      rd_valid = 2'b11;
      step();
    end
    // Head at 63, the retired register is the second free entry
    compare_bit("allocatable", 1'b1, allocatable);
    rd_valid = 2'b11;
    #3;
    compare_preg("prd[0]", 6'h3f, prd[0]);
    compare_preg("prd[1]", 6'h00, prd[1]);
    step();
    report("test_checkpoint", e0);
  endtask

  task automatic test_random();
    logic [PRF_INDEX_SIZE-1:0] retire_q [$];
    logic [CP_INDEX_SIZE-1:0] idx;
    logic [2:0] pick;
    logic recovering;
    int e0;
    int free;
    int npush;
    e0 = errors;
    apply_reset();
    for (int n = 0; n < 300; n++) begin
      free = int'(FL_PTR_SIZE'(m_tail - m_head));
      if (free >= RENAME_WIDTH) begin
        rd_valid = RENAME_WIDTH'(take_bits(RENAME_WIDTH));
      end
      for (int l = 0; l < RENAME_WIDTH; l++) begin
        rs1[l] = ARF_INDEX_SIZE'(take_bits(ARF_INDEX_SIZE));
        rs2[l] = ARF_INDEX_SIZE'(take_bits(ARF_INDEX_SIZE));
        rd[l] = ARF_INDEX_SIZE'(take_bits(ARF_INDEX_SIZE));
      end
      npush = 0;
      for (int l = 0; l < RENAME_WIDTH; l++) begin
        if (retire_q.size() > 0 && take_bits(1) != '0 && free + npush < PRF_SIZE) begin
          retire_req[l] = 1'b1;
          retire_prf[l] = retire_q.pop_front();
          npush++;
        end
      end
      pick = 3'(take_bits(3));
      case (pick)
        3'd0: begin
          check = 1'b1;
          check_idx = CP_INDEX_SIZE'(take_bits(CP_INDEX_SIZE));
        end
        3'd1: begin
          idx = CP_INDEX_SIZE'(take_bits(CP_INDEX_SIZE));
          if (cp_used[idx] &&
              int'(FL_PTR_SIZE'(m_tail - cp_head[idx])) + npush <= PRF_SIZE) begin
            recover = 1'b1;
            recover_idx = idx;
          end
        end
        default: ;
      endcase
      recovering = recover;
      step();
      // Old mappings of kept renames can be retired later
      if (!recovering) begin
        for (int l = 0; l < RENAME_WIDTH; l++) begin
          if (last_prev_valid[l]) begin
            retire_q.push_back(last_prev[l]);
          end
        end
      end
    end
    report("test_random", e0);
  endtask

  initial begin
    clock = 1'b0;
    lfsr = 32'h8521;
    errors = 0;
    tests_done = 0;
    tests_clean = 0;
    reset = 1'b1;
    idle_inputs();
    test_basic_rename();
    test_group_hazards();
    test_exhaustion();
    test_checkpoint();
    test_random();
    $display("%0d of %0d tests without errors, %0d errors in total",
             tests_clean, tests_done, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: sim.f
src/rename_pkg.sv
src/rename_map_table.sv
src/rename_free_list.sv
src/rename_checkpoint.sv
src/rename_stage.sv
testbench/rename_stage_asserts.sv
testbench/rename_stage_tb.sv

// File: Makefile
# Verilator simulation of the rename stage

TOP := rename_stage_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation"
	@echo "  clean  remove build output"

test:
	verilator --binary --timing --assert -Wall -f sim.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "^Test passed$$"

clean:
	rm -rf obj_dir
